//--- delay_line.sv
`timescale 1ns/10ps

module delay_line #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic [WIDTH-1:0] din_i,
  output logic [WIDTH-1:0] dout_o
);

  generate
    if (DEPTH == 0) begin : g_wire

      // No stages at all
      assign dout_o = din_i;

    end else begin : g_shift

      //////////////////////////////////////////////////
      // Shift stages
      //////////////////////////////////////////////////

      // Stage 0 takes the input, the last stage drives the output
      logic [WIDTH-1:0] stage_q [DEPTH];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
          end
        end else begin
          stage_q[0] <= din_i;
          for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
          end
        end
      end

      assign dout_o = stage_q[DEPTH-1];

    end
  endgenerate

endmodule

//--- flist.f
pattern_pkg.sv
delay_line.sv
pattern_store.sv
pattern_player.sv
pattern_player_chk.sv
tb_pattern_player.sv

//--- pattern_data.hex
// One 32-bit playback word per line, hex
// Line order is the table index, 0 to 15
a5a50001
5a5a0102
3c3c0203
c3c30304
0f0f0405
f0f00506
12340607
56780708
9abc0809
def0090a
13570a0b
24680b0c
fedc0c0d
ba980d0e
76540e0f
32100f10

//--- pattern_pkg.sv
package pattern_pkg;

  //////////////////////////////////////////////////
  // Word and address widths
  //////////////////////////////////////////////////

  // One playback word
  localparam int DATA_W = 32;

  // Address as seen on the output port
  localparam int ADDR_W = 32;

  //////////////////////////////////////////////////
  // Table size and pass limit
  //////////////////////////////////////////////////

  // Words in the pattern table
  localparam int DATA_NUM = 16;

  // Full passes before playback stops
  localparam int RUN_CNT = 3;

  // Internal counter widths
  localparam int IDX_W  = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
  localparam int PASS_W = $clog2(RUN_CNT + 1);

  //////////////////////////////////////////////////
  // Output alignment
  //////////////////////////////////////////////////

  // Kept equal so valid, data and address stay aligned
  localparam int VALID_DELAY = 2;
  localparam int DATA_DELAY  = 2;
  localparam int ADDR_DELAY  = 2;

  // Hex text file with the table contents
  localparam string MEM_FILE = "pattern_data.hex";

endpackage

//--- pattern_player.sv
`timescale 1ns/10ps

module pattern_player
  import pattern_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // One read request per high cycle
  input  logic              rd_en_i,

  // Aligned playback outputs
  output logic              rd_valid_o,
  output logic [DATA_W-1:0] rd_data_o,
  output logic [ADDR_W-1:0] rd_addr_o,

  // Playback finished
  output logic              done_o
);

  //////////////////////////////////////////////////
  // Store outputs before alignment
  //////////////////////////////////////////////////

  logic              store_valid;
  logic [DATA_W-1:0] store_data;
  logic [ADDR_W-1:0] store_addr;

  //////////////////////////////////////////////////
  // Pattern table and read control
  //////////////////////////////////////////////////

  // Done is taken straight from the store
  pattern_store u_store (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en_i (rd_en_i),
    .valid_o (store_valid),
    .data_o  (store_data),
    .addr_o  (store_addr),
    .done_o  (done_o)
  );

  //////////////////////////////////////////////////
  // Output delay lines
  //////////////////////////////////////////////////

  // Valid pulse
  delay_line #(
    .DEPTH (VALID_DELAY),
    .WIDTH (1)
  ) u_dly_valid (
    .clk    (clk),
    .rst_n  (rst_n),
    .din_i  (store_valid),
    .dout_o (rd_valid_o)
  );

  // Playback word
  delay_line #(
    .DEPTH (DATA_DELAY),
    .WIDTH (DATA_W)
  ) u_dly_data (
    .clk    (clk),
    .rst_n  (rst_n),
    .din_i  (store_data),
    .dout_o (rd_data_o)
  );

  // Table index of that word
  delay_line #(
    .DEPTH (ADDR_DELAY),
    .WIDTH (ADDR_W)
  ) u_dly_addr (
    .clk    (clk),
    .rst_n  (rst_n),
    .din_i  (store_addr),
    .dout_o (rd_addr_o)
  );

endmodule

//--- pattern_player_chk.sv
`timescale 1ns/10ps

module pattern_player_chk
  import pattern_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic rd_en_i,
  input logic rd_valid_o,
  input logic done_o
);

  // Strobe sample edge to valid sample edge
  localparam int LAT = VALID_DELAY + 1;

  // Count of failed assertions
  int fail_cnt = 0;

  // No pulse unless a strobe was taken before done
  a_valid_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid_o |-> ($past(rd_en_i, LAT) && !$past(done_o, LAT)))
    else begin
      fail_cnt++;
      $error("rd_valid_o high without an accepted strobe three edges earlier");
    end

  // Every accepted strobe gives its pulse
  a_strobe_gives_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(rd_en_i, LAT) && !$past(done_o, LAT)) |-> rd_valid_o)
    else begin
      fail_cnt++;
      $error("accepted strobe gave no rd_valid_o pulse three edges later");
    end

  // Done is a sticky level
  a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $past(done_o) |-> done_o)
    else begin
      fail_cnt++;
      $error("done_o fell after it had risen");
    end

endmodule

bind pattern_player pattern_player_chk u_chk (.*);

//--- pattern_store.sv
`timescale 1ns/10ps

module pattern_store
  import pattern_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // Read strobe, one word per high cycle
  input  logic              rd_en_i,

  // Registered read result
  output logic              valid_o,
  output logic [DATA_W-1:0] data_o,
  output logic [ADDR_W-1:0] addr_o,

  // High once all passes are finished
  output logic              done_o
);

  //////////////////////////////////////////////////
  // Pattern memory
  //////////////////////////////////////////////////

  logic [DATA_W-1:0] mem [DATA_NUM];

  // Table contents come from the hex file at time zero
  initial begin
    $readmemh(MEM_FILE, mem);
  end

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  logic [IDX_W-1:0]  rd_idx;
  logic [PASS_W-1:0] pass_cnt;
  logic              done_q;

  // Read output registers
  logic              valid_q;
  logic [DATA_W-1:0] data_q;
  logic [ADDR_W-1:0] addr_q;

  // Strobe accepted only before the pass limit
  logic              rd_fire;

  // Current read hits the last table entry
  logic              idx_last;

  // Current pass is the final one
  logic              pass_last;

  assign rd_fire   = rd_en_i && !done_q;
  assign idx_last  = (rd_idx == IDX_W'(DATA_NUM - 1));
  assign pass_last = (pass_cnt == PASS_W'(RUN_CNT - 1));

  //////////////////////////////////////////////////
  // Read address
  //////////////////////////////////////////////////

  // Steps once per read and wraps after the last entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_idx <= '0;
    end else if (rd_fire) begin
      if (idx_last) begin
        rd_idx <= '0;
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pass counter
  //////////////////////////////////////////////////

  // One count per completed pass, held at RUN_CNT once done blocks reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_cnt <= '0;
    end else if (rd_fire && idx_last) begin
      pass_cnt <= pass_cnt + 1'b1;
    end
  end

  // Done rises on the edge that reads the final word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (rd_fire && idx_last && pass_last) begin
      done_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // One pulse per accepted strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_fire;
    end
  end

  // Word holds between reads and is cleared after the last pass
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_q <= '0;
    end else if (done_q) begin
      data_q <= '0;
    end else if (rd_fire) begin
      data_q <= mem[rd_idx];
    end
  end

  // Port-wide index of the word just read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (rd_fire) begin
      addr_q <= ADDR_W'(rd_idx);
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign valid_o = valid_q;
  assign data_o  = data_q;
  assign addr_o  = addr_q;
  assign done_o  = done_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the pattern player testbench

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_pattern_player -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_pattern_player +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0

//--- tb_pattern_player.sv
`timescale 1ns/10ps

module tb_pattern_player
  import pattern_pkg::*;
();

  localparam int CLK_HALF    = 4;
  localparam int RST_CYCLES  = 5;
  // Edges from strobe sample to valid sample
  localparam int LATENCY     = VALID_DELAY + 1;
  localparam int TOTAL_READS = RUN_CNT * DATA_NUM;
  localparam int WDOG_CYCLES = RUN_CNT * DATA_NUM * 8 + 200;
  localparam int DRAIN_LIMIT = 20;

  logic              clk;
  logic              rst_n;
  logic              rd_en_i;
  logic              rd_valid_o;
  logic [DATA_W-1:0] rd_data_o;
  logic [ADDR_W-1:0] rd_addr_o;
  logic              done_o;

  // Reference table and words still in flight
  logic [DATA_W-1:0] model [DATA_NUM];
  int                exp_cyc_q [$];
  logic [IDX_W-1:0]  exp_idx_q [$];
  logic [IDX_W-1:0]  next_idx;
  logic [ADDR_W-1:0] last_addr;
  int                cycle;
  int                exp_reads;
  bit                exp_done;
  int                words_seen;
  int                err_cnt;
  integer            seed;

  pattern_player dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en_i    (rd_en_i),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .rd_addr_o  (rd_addr_o),
    .done_o     (done_o)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  task automatic count_error(input string msg);
    err_cnt++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_strobes(input int n);
    rd_en_i = 1'b1;
    repeat (n) next_cycle();
    rd_en_i = 1'b0;
  endtask

  // Wait until every accepted strobe has come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_cyc_q.size() != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    assert (exp_cyc_q.size() == 0)
      else count_error($sformatf("%0d words never came out", exp_cyc_q.size()));
  endtask

  //////////////////////////////////////////////////
  // Output monitor and reference model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle++;
    if (rst_n) begin
      assert (done_o == exp_done)
        else count_error($sformatf("done_o %0b, expected %0b", done_o, exp_done));
      if (rd_valid_o) begin
        assert (exp_cyc_q.size() != 0)
          else count_error("valid pulse with no accepted strobe behind it");
      end
      if (rd_valid_o && exp_cyc_q.size() != 0) begin
        assert (exp_cyc_q[0] == cycle)
          else count_error($sformatf("pulse at edge %0d, expected %0d", cycle, exp_cyc_q[0]));
        assert (rd_addr_o == ADDR_W'(exp_idx_q[0]))
          else count_error($sformatf("rd_addr_o %0d, expected %0d", rd_addr_o, exp_idx_q[0]));
        assert (rd_data_o == model[exp_idx_q[0]])
          else count_error($sformatf("rd_data_o %h, expected %h", rd_data_o,
                                     model[exp_idx_q[0]]));
        last_addr = rd_addr_o;
        words_seen++;
        void'(exp_cyc_q.pop_front());
        void'(exp_idx_q.pop_front());
      end else if (exp_cyc_q.size() != 0) begin
        assert (exp_cyc_q[0] != cycle)
          else count_error("expected valid pulse did not appear");
      end
      // Strobes count only until the pass limit
      if (rd_en_i && exp_reads < TOTAL_READS) begin
        exp_cyc_q.push_back(cycle + LATENCY);
        exp_idx_q.push_back(next_idx);
        next_idx = (next_idx == IDX_W'(DATA_NUM - 1)) ? '0 : next_idx + IDX_W'(1);
        exp_reads++;
        exp_done = (exp_reads == TOTAL_READS);
      end
    end
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic check_reset_values();
    assert (!rd_valid_o && !done_o) else count_error("valid or done high after reset");
    assert (rd_data_o == '0) else count_error($sformatf("rd_data_o %h after reset", rd_data_o));
    assert (rd_addr_o == '0) else count_error($sformatf("rd_addr_o %h after reset", rd_addr_o));
  endtask

  task automatic single_read();
    int seen;
    seen = words_seen;
    drive_strobes(1);
    wait_drain();
    assert (words_seen == seen + 1) else count_error("one strobe did not give one word");
    // Word holds while valid stays low
    repeat (4) begin
      next_cycle();
      assert (!rd_valid_o && rd_data_o == model[0])
        else count_error($sformatf("rd_data_o %h did not hold %h", rd_data_o, model[0]));
    end
  endtask

  task automatic burst_and_gaps();
    int gap;
    drive_strobes(8);
    repeat (10) begin
      gap = $random(seed) & 3;
      repeat (gap) next_cycle();
      drive_strobes(1);
    end
    wait_drain();
    assert (words_seen == exp_reads) else count_error("words lost in burst with gaps");
  endtask

  // Stops one word into the third pass
  task automatic wrap_check();
    while (exp_reads < 2 * DATA_NUM + 1) begin
      drive_strobes(1);
    end
    wait_drain();
    assert (words_seen / DATA_NUM == 2) else count_error("two passes not completed");
    assert (last_addr == '0)
      else count_error($sformatf("rd_addr_o %0d after wrap, expected 0", last_addr));
  endtask

  task automatic run_to_done();
    while (exp_reads < TOTAL_READS) begin
      drive_strobes(1);
    end
    assert (done_o) else count_error("done_o did not rise on the last read");
    drive_strobes(6);
    wait_drain();
    // Long enough for a pulse from the last ignored strobe to show
    repeat (LATENCY) next_cycle();
    assert (rd_data_o == '0)
      else count_error($sformatf("rd_data_o %h after done, expected 0", rd_data_o));
    assert (words_seen == TOTAL_READS)
      else count_error($sformatf("%0d words delivered, expected %0d", words_seen, TOTAL_READS));
  endtask

  initial begin
    seed       = 32'ha8656d48;
    rst_n      = 1'b0;
    rd_en_i    = 1'b0;
    next_idx   = '0;
    last_addr  = '0;
    cycle      = 0;
    exp_reads  = 0;
    exp_done   = 1'b0;
    words_seen = 0;
    err_cnt    = 0;
    $readmemh(MEM_FILE, model);
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_values();
    single_read();
    burst_and_gaps();
    wrap_check();
    run_to_done();
    $display("Errors: %0d testbench checks, %0d assertions", err_cnt, dut.u_chk.fail_cnt);
    if (err_cnt == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles before the tests finished", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule
